// ==== list.f ====
+incdir+test
hdl/pi_pkg.sv
hdl/pi_phase_accum.sv
hdl/pi_code_decode.sv
hdl/pi_code_update.sv
hdl/pi_ctrl_top.sv
test/tb_pi_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# build and run the PI control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_pi_ctrl -o tb_pi_ctrl
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_pi_ctrl)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
	exit 0
fi
exit 1

// ==== test/tb_pi_model.svh ====
// random source, Galois form, taps x^32 + x^22 + x^2 + x + 1
logic [31:0] lfsr_state = 32'hab7213a9;

function automatic logic [31:0] lfsr_next(logic [31:0] s);
	if (s[0])
	begin
		return (s >> 1) ^ 32'h80200003;
	end
	else
	begin
		return s >> 1;
	end
endfunction

function automatic logic rand_bit();
	lfsr_state = lfsr_next(lfsr_state);
	return lfsr_state[0];
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++)
	begin
		r = {r[30:0], rand_bit()};
	end
	return r;
endfunction

// quadrant | index | fine  ->  binary | one-hot | thermometer
function automatic pi_pkg::pi_sel_t decode_code(pi_pkg::phase_code_t c);
	pi_pkg::pi_sel_t s;
	s.stg2  = c[7:6];
	s.stg1  = 8'd1 << c[5:3];
	s.mixer = (8'd1 << c[2:0]) - 8'd1;   // fine value ones from bit 0
	return s;
endfunction

// back from the select fields to a phase code
function automatic pi_pkg::phase_code_t sel_to_code(pi_pkg::pi_sel_t s);
	logic [2:0] idx;
	logic [2:0] cnt;
	idx = '0;
	cnt = '0;
	for (int i = 0; i < 8; i++)
	begin
		if (s.stg1[i])
		begin
			idx = 3'(i);
		end
		if (s.mixer[i])
		begin
			cnt = cnt + 1'b1;
		end
	end
	return {s.stg2, idx, cnt};
endfunction

task automatic check_sel_form(string name, pi_pkg::pi_sel_t s);
	if (!$onehot(s.stg1))
	begin
		$display("%s stage-1 select %b does not have exactly one bit set", name, s.stg1);
		stop_on_error();
	end
	if (((s.mixer & (s.mixer + 8'd1)) != '0) || s.mixer[7])
	begin
		$display("%s mixer weight %b is not a thermometer code", name, s.mixer);
		stop_on_error();
	end
endtask

task automatic compare_sel(string name, pi_pkg::pi_sel_t act, pi_pkg::pi_sel_t exp);
	if (act !== exp)
	begin
		$display("FAILED at %0t: %s = %h, expected %h", $time, name, act, exp);
		stop_on_error();
	end
endtask

task automatic compare_code(string name, pi_pkg::phase_code_t act, pi_pkg::phase_code_t exp);
	if (act !== exp)
	begin
		$display("FAILED at %0t: %s = %h, expected %h", $time, name, act, exp);
		stop_on_error();
	end
endtask

// ==== test/tb_pi_ctrl.sv ====
`timescale 1ns/1ps

module tb_pi_ctrl;

	localparam int RST_CYC    = 5;
	localparam int T1_CYC     = 20;
	localparam int T2_ROUNDS  = 12;
	localparam int T2_RND_CYC = 60;  // worst case per round
	localparam int T3_ROUNDS  = 10;
	localparam int T3_RND_CYC = 8;
	localparam int T4_CYC     = 40;
	localparam int T5_CYC     = 3000;
	localparam int TEST_CYC   = RST_CYC + T1_CYC + T2_ROUNDS * T2_RND_CYC
		+ T3_ROUNDS * T3_RND_CYC + T4_CYC + T5_CYC + 10;
	localparam int WDOG_CYC   = TEST_CYC + 1000;

	logic                clk;
	logic                rb;
	logic                clk_en;
	logic                update;
	logic                step;
	logic                step_up;
	logic                load;
	pi_pkg::phase_code_t load_code;
	pi_pkg::pi_sel_t     o_sel;

	// model state
	pi_pkg::phase_code_t m_code;
	pi_pkg::pi_sel_t     m_dec;
	pi_pkg::pi_sel_t     m_out;
	logic                m_q1;
	logic                m_q2;

	int                  err_cnt = 0;
	int                  chg_cnt = 0;  // o_sel changes seen by the checker
	pi_pkg::pi_sel_t     prev_sel = '0;

	pi_ctrl_top pi_ctrl_top_i
		(
		.clk         (clk),
		.rb          (rb),
		.i_clk_en    (clk_en),
		.i_update    (update),
		.i_step      (step),
		.i_step_up   (step_up),
		.i_load      (load),
		.i_load_code (load_code),
		.o_sel       (o_sel)
		);

	// ends the run on the first error
	task automatic stop_on_error();
		err_cnt++;
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped after an error");
	endtask

	`include "tb_pi_model.svh"

	always #4 clk = ~clk;

	// accumulator, decode stage, request pipe and output register
	always @(posedge clk or negedge rb)
	begin
		if (!rb)
		begin
			m_code <= '0;
			m_dec  <= decode_code('0);
			m_q1   <= 1'b0;
			m_q2   <= 1'b0;
			m_out  <= '0;
		end
		else
		begin
			if (clk_en && m_q1 && !m_q2)
			begin
				m_out <= m_dec;  // strobe seen this cycle
			end
			if (clk_en)
			begin
				m_q1 <= update;
				m_q2 <= m_q1;
			end
			m_dec <= decode_code(m_code);
			if (load)
			begin
				m_code <= load_code;
			end
			else if (step)
			begin
				m_code <= step_up ? m_code + 1'b1 : m_code - 1'b1;
			end
		end
	end

	// mid-cycle check against the model
	always @(negedge clk)
	begin
		if (rb)
		begin
			compare_sel("o_sel", o_sel, m_out);
			if (o_sel != prev_sel)
			begin
				chg_cnt++;
			end
			prev_sel = o_sel;
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// a held request must give one load seen as one output change
	task automatic check_loads(pi_pkg::pi_sel_t old_out);
		int exp_chg;
		exp_chg = (m_out != old_out) ? 1 : 0;
		if (chg_cnt != exp_chg)
		begin
			$display("update request gave %0d output changes instead of %0d", chg_cnt, exp_chg);
			stop_on_error();
		end
	endtask

	initial
	begin
		#(WDOG_CYC * 8);
		$display("timeout: the run did not end within %0d clock cycles", WDOG_CYC);
		stop_on_error();
	end

	initial
	begin
		int                  n_steps;
		int                  hold;
		pi_pkg::phase_code_t code;
		pi_pkg::pi_sel_t     old_out;

		clk       = 1'b0;
		rb        = 1'b0;
		clk_en    = 1'b1;
		update    = 1'b0;
		step      = 1'b0;
		step_up   = 1'b0;
		load      = 1'b0;
		load_code = '0;
		repeat (RST_CYC) @(posedge clk);
		#1;
		rb = 1'b1;

		// output stays clear without an update request
		for (int i = 0; i < T1_CYC; i++)
		begin
			step    = rand_bit();
			step_up = rand_bit();
			next_cycle();
			compare_sel("o_sel", o_sel, '0);
		end

		// step runs with the first two wrapping past 255 and 0
		for (int r = 0; r < T2_ROUNDS; r++)
		begin
			n_steps = 8 + int'(rand_bits(5));
			if (r < 2)
			begin
				step      = 1'b0;
				load      = 1'b1;
				load_code = (r == 0) ? 8'hf9 : 8'h04;
				next_cycle();
				load = 1'b0;
			end
			for (int i = 0; i < n_steps; i++)
			begin
				step    = 1'b1;
				step_up = (r == 0) ? 1'b1 : (r == 1) ? 1'b0 : rand_bit();
				next_cycle();
			end
			old_out = m_out;
			chg_cnt = 0;
			hold    = 2 + int'(rand_bits(3) % 5);
			update  = 1'b1;
			for (int i = 0; i < hold; i++)
			begin
				step    = rand_bit();   // code keeps moving under the request
				step_up = rand_bit();
				next_cycle();
			end
			update = 1'b0;
			step   = 1'b0;
			repeat (4) next_cycle();
			check_loads(old_out);
		end

		// loaded code read back through the select fields
		for (int r = 0; r < T3_ROUNDS; r++)
		begin
			code      = pi_pkg::phase_code_t'(rand_bits(8));
			load      = 1'b1;
			load_code = code;
			next_cycle();
			load   = 1'b0;
			update = 1'b1;
			next_cycle();
			update = 1'b0;
			next_cycle();   // decode plus strobe so loaded two edges after the code
			check_sel_form("o_sel", o_sel);
			compare_code("o_sel code", sel_to_code(o_sel), code);
			repeat (2) next_cycle();
		end

		// enable low freezes the request pipe and the output
		old_out = o_sel;
		clk_en  = 1'b0;
		update  = 1'b1;
		for (int i = 0; i < 12; i++)
		begin
			step    = 1'b1;
			step_up = 1'b1;   // code moves by 12 so the later load shows
			next_cycle();
			compare_sel("o_sel", o_sel, old_out);
		end
		step    = 1'b0;
		chg_cnt = 0;
		clk_en  = 1'b1;
		repeat (6) next_cycle();
		update = 1'b0;
		repeat (4) next_cycle();
		check_loads(old_out);

		// long random mix
		for (int i = 0; i < T5_CYC; i++)
		begin
			if (rand_bits(4) == 0)
			begin
				step      = 1'b0;
				load      = 1'b1;
				load_code = pi_pkg::phase_code_t'(rand_bits(8));
			end
			else
			begin
				load    = 1'b0;
				step    = rand_bit();
				step_up = rand_bit();
			end
			if (rand_bits(4) == 0)
			begin
				clk_en = ~clk_en;
			end
			if (rand_bits(3) == 0)
			begin
				update = ~update;
			end
			next_cycle();
		end
		load   = 1'b0;
		step   = 1'b0;
		update = 1'b0;
		clk_en = 1'b1;
		repeat (4) next_cycle();

		if (err_cnt == 0)
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
		else
		begin
			stop_on_error();
		end
	end

endmodule

// ==== hdl/pi_ctrl_top.sv ====
`timescale 1ns/1ps

module pi_ctrl_top
	(
	input  logic                clk,
	input  logic                rb,
	input  logic                i_clk_en,
	input  logic                i_update,
	input  logic                i_step,
	input  logic                i_step_up,
	input  logic                i_load,
	input  pi_pkg::phase_code_t i_load_code,
	output pi_pkg::pi_sel_t     o_sel
	);

	pi_pkg::phase_code_t phase_code;  // accumulator to decoder
	pi_pkg::pi_sel_t     dec_sel;     // decoder to update block

	// step pulses to phase code
	pi_phase_accum pi_phase_accum_i
		(
		.clk         (clk),
		.rb          (rb),
		.i_step      (i_step),
		.i_step_up   (i_step_up),
		.i_load      (i_load),
		.i_load_code (i_load_code),
		.o_code      (phase_code)
		);

	// code to quadrant, one-hot and thermometer selects
	pi_code_decode pi_code_decode_i
		(
		.clk    (clk),
		.rb     (rb),
		.i_code (phase_code),
		.o_sel  (dec_sel)
		);

	// analog side only sees a new code on an update edge
	pi_code_update pi_code_update_i
		(
		.clk      (clk),
		.rb       (rb),
		.i_clk_en (i_clk_en),
		.i_update (i_update),
		.i_sel    (dec_sel),
		.o_sel    (o_sel)
		);

endmodule

// ==== hdl/pi_code_update.sv ====
`timescale 1ns/1ps

module pi_code_update
	(
	input  logic            clk,
	input  logic            rb,
	input  logic            i_clk_en,   // freezes the whole block when low
	input  logic            i_update,   // rising edge requests a load
	input  pi_pkg::pi_sel_t i_sel,
	output pi_pkg::pi_sel_t o_sel
	);

	logic            req_q1;    // first request flop
	logic            req_q2;    // second request flop
	logic            req_q1_b;
	logic            req_q2_b;
	logic            stb_gate;
	logic            load_stb_b;
	logic            load_stb;
	pi_pkg::pi_sel_t sel_q;

	// both request stages frozen while the enable is low
	always_ff @(posedge clk or negedge rb)
	begin
		if (!rb)
		begin
			req_q1 <= 1'b0;
			req_q2 <= 1'b0;
		end
		else if (i_clk_en)
		begin
			req_q1 <= i_update;
			req_q2 <= req_q1;
		end
	end

	// strobe = en & q1 & ~q2 through the nand pair of the analog cell
	assign req_q1_b   = ~req_q1;
	assign req_q2_b   = ~req_q2;
	assign stb_gate   = ~(req_q1_b | ~i_clk_en);   // q1 seen while enabled
	assign load_stb_b = ~(req_q2_b & stb_gate);
	assign load_stb   = ~load_stb_b;

	// selects held stable between updates
	always_ff @(posedge clk or negedge rb)
	begin
		if (!rb)
		begin
			sel_q <= '0;
		end
		else if (load_stb)
		begin
			sel_q <= i_sel;
		end
	end

	assign o_sel = sel_q;

	// one load per request edge however long the request stays high
	a_stb_single: assert property (@(posedge clk) disable iff (!rb)
		load_stb |=> !load_stb);

	// PI selects move only on a strobe
	a_sel_hold: assert property (@(posedge clk) disable iff (!rb)
		!$stable(sel_q) |-> $past(load_stb));

endmodule

// ==== hdl/pi_code_decode.sv ====
`timescale 1ns/1ps

module pi_code_decode
	(
	input  logic                clk,
	input  logic                rb,
	input  pi_pkg::phase_code_t i_code,
	output pi_pkg::pi_sel_t     o_sel
	);

	logic [pi_pkg::STG2_W-1:0]     quad;
	logic [pi_pkg::STG1_IDX_W-1:0] idx;
	logic [pi_pkg::FINE_W-1:0]     fine;
	pi_pkg::pi_sel_t               sel_d;
	pi_pkg::pi_sel_t               sel_q;

	// split the code into its three fields
	assign quad = i_code[pi_pkg::QUAD_LSB +: pi_pkg::STG2_W];
	assign idx  = i_code[pi_pkg::IDX_LSB +: pi_pkg::STG1_IDX_W];
	assign fine = i_code[pi_pkg::FINE_LSB +: pi_pkg::FINE_W];

	always_comb
	begin
		sel_d.stg2 = quad;  // quadrant passes straight through

		// one bit at the stage-1 index
		for (int i = 0; i < pi_pkg::STG1_W; i++)
		begin
			sel_d.stg1[i] = (int'(idx) == i);
		end

		// fine value counts ones from bit 0 up, top bit stays clear
		for (int j = 0; j < pi_pkg::MIX_W; j++)
		begin
			sel_d.mixer[j] = (j < int'(fine));
		end
	end

	// one stage of retiming ahead of the update block
	always_ff @(posedge clk or negedge rb)
	begin
		if (!rb)
		begin
			sel_q <= pi_pkg::DEC_RST_SEL;
		end
		else
		begin
			sel_q <= sel_d;
		end
	end

	assign o_sel = sel_q;

	// analog stage 1 must never see two phases or none at once
	a_stg1_onehot: assert property (@(posedge clk) disable iff (!rb)
		$onehot(sel_q.stg1));

endmodule

// ==== hdl/pi_phase_accum.sv ====
`timescale 1ns/1ps

module pi_phase_accum
	(
	input  logic                clk,
	input  logic                rb,
	input  logic                i_step,       // one-cycle step pulse
	input  logic                i_step_up,    // step direction, 1 = up
	input  logic                i_load,       // one-cycle load pulse
	input  pi_pkg::phase_code_t i_load_code,
	output pi_pkg::phase_code_t o_code
	);

	pi_pkg::phase_code_t code_q;
	pi_pkg::phase_code_t code_d;
	pi_pkg::phase_code_t code_inc;
	pi_pkg::phase_code_t code_dec;

	// natural wrap at both ends
	assign code_inc = pi_pkg::phase_code_t'(code_q + 1'b1);
	assign code_dec = pi_pkg::phase_code_t'(code_q - 1'b1);

	// load wins over a step
	always_comb
	begin
		code_d = code_q;
		if (i_load)
		begin
			code_d = i_load_code;
		end
		else if (i_step)
		begin
			if (i_step_up)
			begin
				code_d = code_inc;
			end
			else
			begin
				code_d = code_dec;
			end
		end
	end

	always_ff @(posedge clk or negedge rb)
	begin
		if (!rb)
		begin
			code_q <= '0;
		end
		else
		begin
			code_q <= code_d;
		end
	end

	assign o_code = code_q;

	// step source and load source must not collide
	a_no_step_with_load: assert property (@(posedge clk) disable iff (!rb)
		!(i_step && i_load));

endmodule

// ==== hdl/pi_pkg.sv ====
package pi_pkg;

	// widths are fixed by the analog interpolator
	localparam int PHASE_W    = 8;
	localparam int STG2_W     = 2;  // quadrant select, binary
	localparam int STG1_IDX_W = 3;
	localparam int FINE_W     = 3;

	// one-hot and thermometer fields cover every index value
	localparam int STG1_W = 2 ** STG1_IDX_W;
	localparam int MIX_W  = 2 ** FINE_W;

	// field positions inside the phase code, top bit down
	localparam int FINE_LSB = 0;
	localparam int IDX_LSB  = FINE_LSB + FINE_W;
	localparam int QUAD_LSB = IDX_LSB + STG1_IDX_W;

	// quadrant | stage-1 index | fine step, wraps mod 256
	typedef logic [PHASE_W-1:0] phase_code_t;

	// select word as seen by the analog PI
	typedef struct packed
	{
		logic [STG2_W-1:0] stg2;   // stage-2 quadrant
		logic [STG1_W-1:0] stg1;   // stage-1 phase, one-hot
		logic [MIX_W-1:0]  mixer;  // mixer weight, thermometer
	} pi_sel_t;

	// decode of phase code zero
	localparam pi_sel_t DEC_RST_SEL = '{
		stg2:  '0,
		stg1:  STG1_W'(1),
		mixer: '0
	};

endpackage
